// File: rtl/fuel_station_pkg.sv
package fuel_station_pkg;

  // setup has two encodings
  typedef enum logic [1:0] {
    mode_simulate  = 2'b00,
    mode_add_car   = 2'b01,
    mode_setup     = 2'b10,
    mode_setup_alt = 2'b11
  } mode_t;

  typedef enum logic {
    fuel_gasoline = 1'b0,
    fuel_diesel   = 1'b1
  } fuel_t;

  typedef logic [3:0] amount_t;      // fuel units one car needs
  typedef logic [2:0] pump_count_t;
  typedef logic [3:0] car_count_t;   // cars in one queue
  typedef logic [7:0] total_t;       // units still needed per fuel

  typedef struct packed {
    fuel_t   fuel;
    amount_t amount;
  } car_t;

  typedef struct packed {
    logic tick;       // run one time step
    logic clear;      // valid setup so flush queues and pumps
    logic add;        // push a car
    logic car_bad;
    logic setup_bad;
    car_t car;
  } station_cmd_t;

  typedef struct packed {
    logic        configured;
    pump_count_t n_gasoline;
    pump_count_t n_diesel;
  } station_cfg_t;

  localparam int DEFAULT_NUM_PUMPS   = 6;
  localparam int DEFAULT_QUEUE_DEPTH = 8;
  localparam int DEFAULT_MAX_FUEL    = 8;

endpackage

// File: rtl/station_cmd_decoder.sv
`timescale 1ns/1ps

module station_cmd_decoder #(
  parameter int NUM_PUMPS = fuel_station_pkg::DEFAULT_NUM_PUMPS,
  parameter int MAX_FUEL  = fuel_station_pkg::DEFAULT_MAX_FUEL
) (
  input  logic                           CLK,
  input  logic                           reset,
  input  fuel_station_pkg::mode_t        mode,
  input  fuel_station_pkg::pump_count_t  n_gasoline_pumps,
  input  fuel_station_pkg::pump_count_t  n_diesel_pumps,
  input  fuel_station_pkg::amount_t      fuel_amount,
  input  fuel_station_pkg::fuel_t        fuel_type,
  output fuel_station_pkg::station_cmd_t cmd,
  output fuel_station_pkg::station_cfg_t cfg
);
  import fuel_station_pkg::*;

  logic [3:0]   setup_total;
  logic [3:0]   cfg_total;
  logic         setup_ok;
  logic         amount_bad;
  logic         fuel_missing;
  station_cmd_t cmd_next;

  assign setup_total = {1'b0, n_gasoline_pumps} + {1'b0, n_diesel_pumps};
  assign setup_ok    = (setup_total != 4'd0) && (setup_total <= NUM_PUMPS);
  assign cfg_total   = {1'b0, cfg.n_gasoline} + {1'b0, cfg.n_diesel};

  assign amount_bad   = (fuel_amount == '0) || (fuel_amount > MAX_FUEL);
  assign fuel_missing = (fuel_type == fuel_gasoline) ? (cfg.n_gasoline == '0)
                                                     : (cfg.n_diesel == '0);

  always_comb begin
    cmd_next            = '0;
    cmd_next.car.fuel   = fuel_type;
    cmd_next.car.amount = fuel_amount;
    case (mode)
      mode_simulate: begin
        cmd_next.tick = cfg.configured;   // ignored until first setup
      end
      mode_add_car: begin
        cmd_next.tick    = cfg.configured;   // adding a car is a step too
        cmd_next.add     = cfg.configured;
        cmd_next.car_bad = cfg.configured && (amount_bad || fuel_missing);
      end
      mode_setup, mode_setup_alt: begin
        cmd_next.clear     = setup_ok;
        cmd_next.setup_bad = !setup_ok;
      end
      default: begin
        cmd_next = '0;
      end
    endcase
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      cmd <= '0;
      cfg <= '0;
    end else begin
      cmd <= cmd_next;
      if (cmd_next.clear) begin   // bad setup keeps old config
        cfg.configured <= 1'b1;
        cfg.n_gasoline <= n_gasoline_pumps;
        cfg.n_diesel   <= n_diesel_pumps;
      end
    end
  end

  cfg_in_range: assert property (@(posedge CLK) disable iff (reset)
    cfg.configured |-> (cfg_total >= 4'd1) && (cfg_total <= NUM_PUMPS));

endmodule

// File: rtl/fuel_queue.sv
`timescale 1ns/1ps

module fuel_queue #(
  parameter int                      QUEUE_DEPTH = fuel_station_pkg::DEFAULT_QUEUE_DEPTH,
  parameter fuel_station_pkg::fuel_t FUEL        = fuel_station_pkg::fuel_gasoline
) (
  input  logic                           CLK,
  input  logic                           reset,
  input  fuel_station_pkg::station_cmd_t cmd,
  input  fuel_station_pkg::station_cfg_t cfg,
  input  logic                           pop,
  output fuel_station_pkg::amount_t      head,
  output logic                           head_valid,
  output fuel_station_pkg::car_count_t   count,
  output fuel_station_pkg::total_t       queued_sum,
  output logic                           not_full,
  output logic                           reject
);
  import fuel_station_pkg::*;

  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;

  amount_t          slots [QUEUE_DEPTH];
  logic [PTR_W-1:0] front;
  logic [PTR_W-1:0] back;
  logic             has_pumps;   // latched on clear
  logic             full;
  logic             push_req;
  logic             push;
  pump_count_t      fuel_pumps;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign fuel_pumps = (FUEL == fuel_gasoline) ? cfg.n_gasoline : cfg.n_diesel;
  assign full       = (count >= QUEUE_DEPTH);   // count at start of step
  assign push_req   = cmd.add && !cmd.car_bad && (cmd.car.fuel == FUEL);
  assign push       = push_req && !full;

  assign head       = slots[front];
  assign head_valid = (count != '0);
  assign not_full   = has_pumps && !full;   // no pumps reads as full

  always_ff @(posedge CLK) begin
    if (reset) begin
      front      <= '0;
      back       <= '0;
      count      <= '0;
      queued_sum <= '0;
      has_pumps  <= 1'b0;
      reject     <= 1'b0;
    end else if (cmd.clear) begin
      front      <= '0;
      back       <= '0;
      count      <= '0;
      queued_sum <= '0;
      has_pumps  <= (fuel_pumps != '0);
      reject     <= 1'b0;
    end else begin
      if (pop) begin
        front <= next_ptr(front);
      end
      if (push) begin
        back <= next_ptr(back);
      end
      count      <= count + car_count_t'(push) - car_count_t'(pop);
      queued_sum <= queued_sum + (push ? total_t'(cmd.car.amount) : '0)
                               - (pop ? total_t'(head) : '0);
      reject     <= push_req && full;   // car is dropped
    end
  end

  always_ff @(posedge CLK) begin
    if (push) begin
      slots[back] <= cmd.car.amount;
    end
  end

  // the pump bank must only pop a car that is there
  pop_needs_car: assert property (@(posedge CLK) disable iff (reset)
    pop |-> head_valid);

  count_bounded: assert property (@(posedge CLK) disable iff (reset)
    count <= QUEUE_DEPTH);

endmodule

// File: rtl/pump_bank.sv
`timescale 1ns/1ps

module pump_bank #(
  parameter int NUM_PUMPS = fuel_station_pkg::DEFAULT_NUM_PUMPS
) (
  input  logic                           CLK,
  input  logic                           reset,
  input  fuel_station_pkg::station_cmd_t cmd,
  input  fuel_station_pkg::station_cfg_t cfg,
  input  fuel_station_pkg::amount_t      gas_head,
  input  logic                           gas_head_valid,
  input  fuel_station_pkg::amount_t      diesel_head,
  input  logic                           diesel_head_valid,
  output logic                           gas_pop,
  output logic                           diesel_pop,
  output logic [NUM_PUMPS-1:0]           pump_idle,
  output fuel_station_pkg::total_t       gas_remaining,
  output fuel_station_pkg::total_t       diesel_remaining
);
  import fuel_station_pkg::*;

  amount_t              remaining [NUM_PUMPS];   // units left at each pump
  logic [NUM_PUMPS-1:0] gas_mask;
  logic [NUM_PUMPS-1:0] diesel_mask;
  logic [NUM_PUMPS-1:0] busy;
  logic [NUM_PUMPS-1:0] gas_free;
  logic [NUM_PUMPS-1:0] diesel_free;
  logic [NUM_PUMPS-1:0] gas_grant;
  logic [NUM_PUMPS-1:0] diesel_grant;

  always_comb begin
    gas_remaining    = '0;
    diesel_remaining = '0;
    for (int i = 0; i < NUM_PUMPS; i++) begin
      busy[i] = (remaining[i] != '0);
      if (gas_mask[i]) begin
        gas_remaining = gas_remaining + total_t'(remaining[i]);
      end
      if (diesel_mask[i]) begin
        diesel_remaining = diesel_remaining + total_t'(remaining[i]);
      end
    end
  end

  assign gas_free    = gas_mask & ~busy;
  assign diesel_free = diesel_mask & ~busy;

  // lowest free pump of each group
  assign gas_grant    = gas_free & (~gas_free + 1'b1);
  assign diesel_grant = diesel_free & (~diesel_free + 1'b1);

  assign gas_pop    = cmd.tick && gas_head_valid && (gas_free != '0);
  assign diesel_pop = cmd.tick && diesel_head_valid && (diesel_free != '0);
  assign pump_idle  = gas_free | diesel_free;   // unconfigured pumps stay low

  // gasoline group first, diesel right after it
  always_ff @(posedge CLK) begin
    if (reset) begin
      gas_mask    <= '0;
      diesel_mask <= '0;
    end else if (cmd.clear) begin
      for (int i = 0; i < NUM_PUMPS; i++) begin
        gas_mask[i]    <= (i < cfg.n_gasoline);
        diesel_mask[i] <= (i >= cfg.n_gasoline) &&
                          (i < cfg.n_gasoline + cfg.n_diesel);
      end
    end
  end

  always_ff @(posedge CLK) begin
    for (int i = 0; i < NUM_PUMPS; i++) begin
      if (reset || cmd.clear) begin
        remaining[i] <= '0;
      end else if (cmd.tick) begin
        if (gas_pop && gas_grant[i]) begin
          remaining[i] <= gas_head;   // loaded pump skips this step
        end else if (diesel_pop && diesel_grant[i]) begin
          remaining[i] <= diesel_head;
        end else if (busy[i]) begin
          remaining[i] <= remaining[i] - 1'b1;   // one unit dispensed
        end
      end
    end
  end

  // a pump that takes a car has units to dispense in the next step
  for (genvar g = 0; g < NUM_PUMPS; g++) begin : g_pump_chk
    load_not_empty: assert property (@(posedge CLK) disable iff (reset)
      ((gas_pop && gas_grant[g]) || (diesel_pop && diesel_grant[g])) |=> busy[g]);
  end

endmodule

// File: rtl/station_status.sv
`timescale 1ns/1ps

module station_status #(
  parameter int NUM_PUMPS = fuel_station_pkg::DEFAULT_NUM_PUMPS
) (
  input  logic                           CLK,
  input  logic                           reset,
  input  fuel_station_pkg::station_cmd_t cmd,
  input  fuel_station_pkg::car_count_t   gas_count,
  input  fuel_station_pkg::car_count_t   diesel_count,
  input  fuel_station_pkg::total_t       gas_queued_sum,
  input  fuel_station_pkg::total_t       diesel_queued_sum,
  input  logic                           gas_not_full,
  input  logic                           diesel_not_full,
  input  logic                           gas_reject,
  input  logic                           diesel_reject,
  input  logic [NUM_PUMPS-1:0]           pump_idle,
  input  fuel_station_pkg::total_t       gas_remaining,
  input  fuel_station_pkg::total_t       diesel_remaining,
  output logic [0:NUM_PUMPS-1]           pump_status,
  output logic                           is_gasoline_queue_not_full,
  output logic                           is_diesel_queue_not_full,
  output fuel_station_pkg::car_count_t   n_cars_in_gasoline_queue,
  output fuel_station_pkg::car_count_t   n_cars_in_diesel_queue,
  output fuel_station_pkg::total_t       total_gasoline_needed,
  output fuel_station_pkg::total_t       total_diesel_needed,
  output logic                           invalid_gasoline_car,
  output logic                           invalid_diesel_car,
  output logic                           invalid_setup_params
);
  import fuel_station_pkg::*;

  // decode flags wait one cycle to line up with queue rejects
  logic gas_bad_d;
  logic diesel_bad_d;
  logic setup_bad_d;

  always_ff @(posedge CLK) begin
    if (reset) begin
      gas_bad_d                  <= 1'b0;
      diesel_bad_d               <= 1'b0;
      setup_bad_d                <= 1'b0;
      pump_status                <= '0;
      is_gasoline_queue_not_full <= 1'b0;
      is_diesel_queue_not_full   <= 1'b0;
      n_cars_in_gasoline_queue   <= '0;
      n_cars_in_diesel_queue     <= '0;
      total_gasoline_needed      <= '0;
      total_diesel_needed        <= '0;
      invalid_gasoline_car       <= 1'b0;
      invalid_diesel_car         <= 1'b0;
      invalid_setup_params       <= 1'b0;
    end else begin
      gas_bad_d    <= cmd.car_bad && (cmd.car.fuel == fuel_gasoline);
      diesel_bad_d <= cmd.car_bad && (cmd.car.fuel == fuel_diesel);
      setup_bad_d  <= cmd.setup_bad;
      for (int i = 0; i < NUM_PUMPS; i++) begin
        pump_status[i] <= pump_idle[i];   // pump 0 is the leftmost bit
      end
      is_gasoline_queue_not_full <= gas_not_full;
      is_diesel_queue_not_full   <= diesel_not_full;
      n_cars_in_gasoline_queue   <= gas_count;
      n_cars_in_diesel_queue     <= diesel_count;
      total_gasoline_needed      <= gas_queued_sum + gas_remaining;
      total_diesel_needed        <= diesel_queued_sum + diesel_remaining;
      invalid_gasoline_car       <= gas_bad_d || gas_reject;
      invalid_diesel_car         <= diesel_bad_d || diesel_reject;
      invalid_setup_params       <= setup_bad_d;
    end
  end

endmodule

// File: rtl/fuel_station_top.sv
`timescale 1ns/1ps

module fuel_station_top #(
  parameter int NUM_PUMPS   = fuel_station_pkg::DEFAULT_NUM_PUMPS,
  parameter int QUEUE_DEPTH = fuel_station_pkg::DEFAULT_QUEUE_DEPTH,
  parameter int MAX_FUEL    = fuel_station_pkg::DEFAULT_MAX_FUEL
) (
  input  logic [1:0]                    mode,
  input  fuel_station_pkg::pump_count_t n_gasoline_pumps,
  input  fuel_station_pkg::pump_count_t n_diesel_pumps,
  input  fuel_station_pkg::amount_t     fuel_amount,
  input  logic                          fuel_type,
  input  logic                          CLK,
  input  logic                          reset,
  output logic [0:NUM_PUMPS-1]          pump_status,
  output logic                          is_gasoline_queue_not_full,
  output logic                          is_diesel_queue_not_full,
  output fuel_station_pkg::car_count_t  n_cars_in_gasoline_queue,
  output fuel_station_pkg::car_count_t  n_cars_in_diesel_queue,
  output fuel_station_pkg::total_t      total_gasoline_needed,
  output fuel_station_pkg::total_t      total_diesel_needed,
  output logic                          invalid_gasoline_car,
  output logic                          invalid_diesel_car,
  output logic                          invalid_setup_params
);
  import fuel_station_pkg::*;

  station_cmd_t         cmd;
  station_cfg_t         cfg;
  amount_t              gas_head;
  amount_t              diesel_head;
  logic                 gas_head_valid;
  logic                 diesel_head_valid;
  car_count_t           gas_count;
  car_count_t           diesel_count;
  total_t               gas_queued_sum;
  total_t               diesel_queued_sum;
  logic                 gas_not_full;
  logic                 diesel_not_full;
  logic                 gas_reject;
  logic                 diesel_reject;
  logic                 gas_pop;
  logic                 diesel_pop;
  logic [NUM_PUMPS-1:0] pump_idle;
  total_t               gas_remaining;
  total_t               diesel_remaining;

  station_cmd_decoder #(.NUM_PUMPS(NUM_PUMPS), .MAX_FUEL(MAX_FUEL)) decoder (
    .CLK(CLK), .reset(reset),
    .mode(mode_t'(mode)),
    .n_gasoline_pumps(n_gasoline_pumps), .n_diesel_pumps(n_diesel_pumps),
    .fuel_amount(fuel_amount), .fuel_type(fuel_t'(fuel_type)),
    .cmd(cmd), .cfg(cfg)
  );

  fuel_queue #(.QUEUE_DEPTH(QUEUE_DEPTH), .FUEL(fuel_gasoline)) gas_queue (
    .CLK(CLK), .reset(reset), .cmd(cmd), .cfg(cfg), .pop(gas_pop),
    .head(gas_head), .head_valid(gas_head_valid), .count(gas_count),
    .queued_sum(gas_queued_sum), .not_full(gas_not_full), .reject(gas_reject)
  );

  fuel_queue #(.QUEUE_DEPTH(QUEUE_DEPTH), .FUEL(fuel_diesel)) diesel_queue (
    .CLK(CLK), .reset(reset), .cmd(cmd), .cfg(cfg), .pop(diesel_pop),
    .head(diesel_head), .head_valid(diesel_head_valid), .count(diesel_count),
    .queued_sum(diesel_queued_sum), .not_full(diesel_not_full),
    .reject(diesel_reject)
  );

  pump_bank #(.NUM_PUMPS(NUM_PUMPS)) pumps (
    .CLK(CLK), .reset(reset), .cmd(cmd), .cfg(cfg),
    .gas_head(gas_head), .gas_head_valid(gas_head_valid),
    .diesel_head(diesel_head), .diesel_head_valid(diesel_head_valid),
    .gas_pop(gas_pop), .diesel_pop(diesel_pop), .pump_idle(pump_idle),
    .gas_remaining(gas_remaining), .diesel_remaining(diesel_remaining)
  );

  station_status #(.NUM_PUMPS(NUM_PUMPS)) status (
    .CLK(CLK), .reset(reset), .cmd(cmd),
    .gas_count(gas_count), .diesel_count(diesel_count),
    .gas_queued_sum(gas_queued_sum), .diesel_queued_sum(diesel_queued_sum),
    .gas_not_full(gas_not_full), .diesel_not_full(diesel_not_full),
    .gas_reject(gas_reject), .diesel_reject(diesel_reject),
    .pump_idle(pump_idle),
    .gas_remaining(gas_remaining), .diesel_remaining(diesel_remaining),
    .pump_status(pump_status),
    .is_gasoline_queue_not_full(is_gasoline_queue_not_full),
    .is_diesel_queue_not_full(is_diesel_queue_not_full),
    .n_cars_in_gasoline_queue(n_cars_in_gasoline_queue),
    .n_cars_in_diesel_queue(n_cars_in_diesel_queue),
    .total_gasoline_needed(total_gasoline_needed),
    .total_diesel_needed(total_diesel_needed),
    .invalid_gasoline_car(invalid_gasoline_car),
    .invalid_diesel_car(invalid_diesel_car),
    .invalid_setup_params(invalid_setup_params)
  );

endmodule

// File: tb/station_model.svh
`ifndef STATION_MODEL_SVH
`define STATION_MODEL_SVH

// fuel index 0 is gasoline, 1 is diesel
typedef struct packed {
  logic                           configured;
  pump_count_t [1:0]              n_pumps;
  car_count_t [1:0]               cnt;
  amount_t [1:0][QUEUE_DEPTH-1:0] q;          // entry 0 is the queue head
  amount_t [NUM_PUMPS-1:0]        rem;        // units left per pump
  logic [1:0]                     bad_car;
  logic                           bad_setup;
} model_t;

typedef struct packed {
  logic [0:NUM_PUMPS-1] pumps;
  logic                 gas_not_full;
  logic                 diesel_not_full;
  car_count_t           gas_cars;
  car_count_t           diesel_cars;
  total_t               gas_total;
  total_t               diesel_total;
  logic                 bad_gas;
  logic                 bad_diesel;
  logic                 bad_setup;
} expect_t;

function automatic int group_start(model_t st, int f);
  return (f == 0) ? 0 : int'(st.n_pumps[0]);   // diesel follows gasoline
endfunction

// one command applied to the station as one time step
function automatic model_t step_model(model_t st, logic [1:0] m, pump_count_t ng,
                                      pump_count_t nd, amount_t amt, logic ft);
  model_t               nx;
  int                   lo;
  int                   hi;
  logic                 granted;
  logic [NUM_PUMPS-1:0] loaded;
  nx           = st;
  nx.bad_car   = '0;
  nx.bad_setup = 1'b0;
  loaded       = '0;
  if (m[1]) begin
    if ((int'(ng) + int'(nd) >= 1) && (int'(ng) + int'(nd) <= NUM_PUMPS)) begin
      nx            = '0;   // valid setup empties everything
      nx.configured = 1'b1;
      nx.n_pumps[0] = ng;
      nx.n_pumps[1] = nd;
    end else begin
      nx.bad_setup = 1'b1;
    end
  end else if (st.configured) begin
    for (int f = 0; f < 2; f++) begin
      lo      = group_start(st, f);
      hi      = lo + int'(st.n_pumps[f]);
      granted = 1'b0;
      for (int i = lo; i < hi; i++) begin
        if (!granted && (st.cnt[f] != 0) && (st.rem[i] == '0)) begin
          nx.rem[i] = st.q[f][0];   // lowest idle pump takes the head
          loaded[i] = 1'b1;
          granted   = 1'b1;
        end
      end
      if (granted) begin
        for (int j = 0; j < QUEUE_DEPTH - 1; j++) begin
          nx.q[f][j] = st.q[f][j+1];
        end
        nx.q[f][QUEUE_DEPTH-1] = '0;
        nx.cnt[f]              = st.cnt[f] - 1'b1;
      end
    end
    for (int i = 0; i < NUM_PUMPS; i++) begin
      if (!loaded[i] && (st.rem[i] != '0)) begin
        nx.rem[i] = st.rem[i] - 1'b1;   // one unit dispensed
      end
    end
    if (m == mode_add_car) begin
      // fullness is judged on the count at the start of the step
      if ((amt == '0) || (amt > MAX_FUEL) || (st.n_pumps[ft] == '0) ||
          (st.cnt[ft] >= QUEUE_DEPTH)) begin
        nx.bad_car[ft] = 1'b1;
      end else begin
        nx.q[ft][nx.cnt[ft]] = amt;
        nx.cnt[ft]           = nx.cnt[ft] + 1'b1;
      end
    end
  end
  return nx;
endfunction

function automatic expect_t expected_outputs(model_t st);
  expect_t      e;
  total_t [1:0] sum;
  logic [1:0]   nf;
  int           lo;
  int           hi;
  e = '0;
  for (int f = 0; f < 2; f++) begin
    lo     = group_start(st, f);
    hi     = lo + int'(st.n_pumps[f]);
    sum[f] = '0;
    for (int i = lo; i < hi; i++) begin
      e.pumps[i] = (st.rem[i] == '0);
      sum[f]     = sum[f] + total_t'(st.rem[i]);
    end
    for (int j = 0; j < int'(st.cnt[f]); j++) begin
      sum[f] = sum[f] + total_t'(st.q[f][j]);
    end
    nf[f] = (st.n_pumps[f] != '0) && (st.cnt[f] < QUEUE_DEPTH);   // no pumps reads as full
  end
  e.gas_not_full    = nf[0];
  e.diesel_not_full = nf[1];
  e.gas_cars        = st.cnt[0];
  e.diesel_cars     = st.cnt[1];
  e.gas_total       = sum[0];
  e.diesel_total    = sum[1];
  e.bad_gas         = st.bad_car[0];
  e.bad_diesel      = st.bad_car[1];
  e.bad_setup       = st.bad_setup;
  return e;
endfunction

`endif

// File: tb/fuel_station_tb.sv
`timescale 1ns/1ps

module fuel_station_tb;
  import fuel_station_pkg::*;

  localparam int NUM_PUMPS     = DEFAULT_NUM_PUMPS;
  localparam int QUEUE_DEPTH   = DEFAULT_QUEUE_DEPTH;
  localparam int MAX_FUEL      = DEFAULT_MAX_FUEL;
  localparam int CLK_PERIOD    = 10;
  localparam int RESET_CYCLES  = 10;
  localparam int DIRECTED_CMDS = 60;   // upper bound for the directed part
  localparam int RANDOM_ROUNDS = 4;
  localparam int ROUND_CMDS    = 120;
  localparam int DRAIN_CMDS    = 8;
  localparam int PLANNED_CMDS  = RESET_CYCLES + DIRECTED_CMDS +
                                 RANDOM_ROUNDS * (ROUND_CMDS + 1) + DRAIN_CMDS;

  `include "station_model.svh"

  logic                 CLK;
  logic                 reset;
  logic [1:0]           mode;
  pump_count_t          n_gasoline_pumps;
  pump_count_t          n_diesel_pumps;
  amount_t              fuel_amount;
  logic                 fuel_type;
  logic [0:NUM_PUMPS-1] pump_status;
  logic                 is_gasoline_queue_not_full;
  logic                 is_diesel_queue_not_full;
  car_count_t           n_cars_in_gasoline_queue;
  car_count_t           n_cars_in_diesel_queue;
  total_t               total_gasoline_needed;
  total_t               total_diesel_needed;
  logic                 invalid_gasoline_car;
  logic                 invalid_diesel_car;
  logic                 invalid_setup_params;

  model_t     model;
  expect_t    exp_line [3];        // expected results on their way through the pipeline
  logic [2:0] line_valid = '0;
  int         errors     = 0;
  int         checks     = 0;
  int         cmd_count  = 0;
  integer     seed       = 32'ha58418f7;

  fuel_station_top #(
    .NUM_PUMPS(NUM_PUMPS), .QUEUE_DEPTH(QUEUE_DEPTH), .MAX_FUEL(MAX_FUEL)
  ) DUT (
    .mode(mode), .n_gasoline_pumps(n_gasoline_pumps), .n_diesel_pumps(n_diesel_pumps),
    .fuel_amount(fuel_amount), .fuel_type(fuel_type), .CLK(CLK), .reset(reset),
    .pump_status(pump_status),
    .is_gasoline_queue_not_full(is_gasoline_queue_not_full),
    .is_diesel_queue_not_full(is_diesel_queue_not_full),
    .n_cars_in_gasoline_queue(n_cars_in_gasoline_queue),
    .n_cars_in_diesel_queue(n_cars_in_diesel_queue),
    .total_gasoline_needed(total_gasoline_needed),
    .total_diesel_needed(total_diesel_needed),
    .invalid_gasoline_car(invalid_gasoline_car),
    .invalid_diesel_car(invalid_diesel_car),
    .invalid_setup_params(invalid_setup_params)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  initial begin
    #(CLK_PERIOD * (PLANNED_CMDS + 20));
    $display("timeout: the run did not finish in time, %0d errors so far", errors);
    $display("Checks failed");
    $finish;
  end

  task automatic check_count(string name, car_count_t expected, car_count_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("error %s expected %h actual %h at %0t", name, expected, actual, $time);
    end
  endtask

  task automatic check_total(string name, total_t expected, total_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("error %s expected %h actual %h at %0t", name, expected, actual, $time);
    end
  endtask

  task automatic check_pumps(string name, logic [0:NUM_PUMPS-1] expected,
                             logic [0:NUM_PUMPS-1] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("error %s expected %h actual %h at %0t", name, expected, actual, $time);
    end
  endtask

  task automatic check_flag(string name, logic expected, logic actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("error %s expected %h actual %h at %0t", name, expected, actual, $time);
    end
  endtask

  task automatic compare_outputs(expect_t e);
    check_pumps("pump_status", e.pumps, pump_status);
    check_flag("is_gasoline_queue_not_full", e.gas_not_full, is_gasoline_queue_not_full);
    check_flag("is_diesel_queue_not_full", e.diesel_not_full, is_diesel_queue_not_full);
    check_count("n_cars_in_gasoline_queue", e.gas_cars, n_cars_in_gasoline_queue);
    check_count("n_cars_in_diesel_queue", e.diesel_cars, n_cars_in_diesel_queue);
    check_total("total_gasoline_needed", e.gas_total, total_gasoline_needed);
    check_total("total_diesel_needed", e.diesel_total, total_diesel_needed);
    check_flag("invalid_gasoline_car", e.bad_gas, invalid_gasoline_car);
    check_flag("invalid_diesel_car", e.bad_diesel, invalid_diesel_car);
    check_flag("invalid_setup_params", e.bad_setup, invalid_setup_params);
  endtask

  // model steps on the edge where the decoder samples the inputs
  always @(posedge CLK) begin
    if (reset) begin
      model = '0;
    end else begin
      model = step_model(model, mode, n_gasoline_pumps, n_diesel_pumps,
                         fuel_amount, fuel_type);
    end
    exp_line[2] = exp_line[1];
    exp_line[1] = exp_line[0];
    exp_line[0] = expected_outputs(model);
    line_valid  = {line_valid[1:0], 1'b1};
  end

  // outputs settle two edges after sampling, compare half a cycle later
  always @(negedge CLK) begin
    if (line_valid[2]) begin
      compare_outputs(exp_line[2]);
    end
  end

  task automatic drive_command(logic [1:0] m, pump_count_t ng, pump_count_t nd,
                               amount_t amt, logic ft);
    @(negedge CLK);
    mode             = m;
    n_gasoline_pumps = ng;
    n_diesel_pumps   = nd;
    fuel_amount      = amt;
    fuel_type        = ft;
    cmd_count++;
  endtask

  task automatic setup_pumps(pump_count_t ng, pump_count_t nd);
    drive_command(mode_setup, ng, nd, '0, fuel_gasoline);
  endtask

  task automatic add_car(logic ft, amount_t amt);
    drive_command(mode_add_car, '0, '0, amt, ft);
  endtask

  task automatic simulate_step();
    drive_command(mode_simulate, '0, '0, '0, fuel_gasoline);
  endtask

  task automatic random_round(pump_count_t ng, pump_count_t nd);
    logic [31:0] r;
    setup_pumps(ng, nd);
    for (int i = 0; i < ROUND_CMDS; i++) begin
      r = $random(seed);
      if (r[3:0] < 4'd9) begin
        add_car(r[4], amount_t'(r[11:8] % 10));   // 0 and 9 are bad amounts
      end else if ((r[3:0] == 4'd15) && r[5]) begin
        setup_pumps(r[14:12], r[18:16]);   // may be out of range
      end else begin
        simulate_step();
      end
    end
  endtask

  initial begin
    reset            = 1'b1;
    mode             = mode_simulate;
    n_gasoline_pumps = '0;
    n_diesel_pumps   = '0;
    fuel_amount      = '0;
    fuel_type        = fuel_gasoline;
    repeat (RESET_CYCLES) @(negedge CLK);
    reset = 1'b0;

    add_car(fuel_gasoline, 4'd3);   // ignored before setup
    add_car(fuel_diesel, 4'd5);
    simulate_step();

    setup_pumps(3'd0, 3'd0);
    setup_pumps(3'd4, 3'd3);
    setup_pumps(3'd7, 3'd7);
    setup_pumps(3'd3, 3'd2);
    add_car(fuel_gasoline, 4'd2);
    simulate_step();
    setup_pumps(3'd0, 3'd0);   // old configuration stays
    add_car(fuel_diesel, 4'd4);
    setup_pumps(3'd2, 3'd2);
    simulate_step();

    setup_pumps(3'd2, 3'd0);   // no diesel pumps
    add_car(fuel_gasoline, 4'd0);
    add_car(fuel_gasoline, 4'd9);
    add_car(fuel_gasoline, 4'd15);
    add_car(fuel_diesel, 4'd3);
    add_car(fuel_gasoline, 4'd8);
    simulate_step();

    // single busy pump per fuel so the queues fill up
    setup_pumps(3'd1, 3'd1);
    repeat (QUEUE_DEPTH + 4) add_car(fuel_gasoline, 4'd8);
    repeat (QUEUE_DEPTH + 4) add_car(fuel_diesel, 4'd8);

    random_round(3'd3, 3'd3);
    random_round(3'd1, 3'd4);
    random_round(3'd5, 3'd0);
    random_round(3'd0, 3'd2);

    repeat (DRAIN_CMDS / 2) simulate_step();
    repeat (4) @(posedge CLK);

    if (checks == 0) begin
      $display("no output comparisons were made");
      errors++;
    end
    $display("%0d commands, %0d checks, %0d errors", cmd_count, checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: sources.f
+incdir+tb
rtl/fuel_station_pkg.sv
rtl/station_cmd_decoder.sv
rtl/fuel_queue.sv
rtl/pump_bank.sv
rtl/station_status.sv
rtl/fuel_station_top.sv
tb/fuel_station_tb.sv
